// ==== src/rv32i_mem_consts.svh ====
`ifndef RV32I_MEM_CONSTS_SVH
`define RV32I_MEM_CONSTS_SVH

// ============================================================================
// Datapath and data memory sizing
// ============================================================================

// Data word width
`define XLEN 32

// Number of words in the data memory
`define DMEM_WORDS 256

// Word index width, taken from address bits 9:2
`define DMEM_INDEX_BITS 8

`endif

// ==== src/rv32i_mem_pkg.sv ====
package rv32i_mem_pkg;

    // ========================================================================
    // Major opcodes seen by the memory and write-back stages
    // ========================================================================
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    // Load and store width codes
    typedef enum logic [2:0] {
        mem_byte          = 3'b000,
        mem_half          = 3'b001,
        mem_word          = 3'b010,
        mem_byte_unsigned = 3'b100,
        mem_half_unsigned = 3'b101
    } mem_funct3_t;

    // ========================================================================
    // Instruction word views
    // ========================================================================
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_view_t;

    // Bits 11:7 hold the low immediate here, not rd
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_view_t;

    typedef union packed {
        inst_i_view_t i;
        inst_s_view_t s;
    } rv32_inst_t;

endpackage

// ==== src/ex_mem_reg.sv ====
`timescale 1ns/1ps

`include "rv32i_mem_consts.svh"

module ex_mem_reg (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     in_valid,
    input  rv32i_mem_pkg::rv32_inst_t in_inst,
    input  logic [`XLEN-1:0]         in_pc,
    input  logic [`XLEN-1:0]         in_alu_out,
    input  logic [`XLEN-1:0]         in_rs2_v,

    output logic                     mem_valid,
    output rv32i_mem_pkg::rv32_inst_t mem_inst,
    output logic [`XLEN-1:0]         mem_pc,
    output logic [`XLEN-1:0]         mem_alu_out,
    output logic [`XLEN-1:0]         mem_rs2_v
);

    // ========================================================================
    // Valid bit
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= in_valid;
        end
    end

    // ========================================================================
    // Payload loaded every cycle
    // ========================================================================
    always_ff @(posedge clk) begin
        mem_inst    <= in_inst;
        mem_pc      <= in_pc;
        mem_alu_out <= in_alu_out;
        mem_rs2_v   <= in_rs2_v;
    end

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

`include "rv32i_mem_consts.svh"

module mem_stage (
    input  logic                      mem_valid,
    input  rv32i_mem_pkg::rv32_inst_t mem_inst,
    input  logic [`XLEN-1:0]          mem_alu_out,
    input  logic [`XLEN-1:0]          mem_rs2_v,

    output logic [`XLEN-1:0]          dmem_addr,
    output logic [3:0]                dmem_rmask,
    output logic [3:0]                dmem_wmask,
    output logic [`XLEN-1:0]          dmem_wdata
);

    logic       is_load;
    logic       is_store;
    logic [2:0] funct3;
    logic [1:0] offset;
    logic [3:0] lane_mask;

    // ========================================================================
    // Decode and lane selection
    // ========================================================================
    always_comb begin
        is_load  = (mem_inst.i.opcode == rv32i_mem_pkg::opc_load);
        is_store = (mem_inst.s.opcode == rv32i_mem_pkg::opc_store);

        // Same bit positions in both views
        funct3 = mem_inst.i.funct3;
        offset = mem_alu_out[1:0];

        case (rv32i_mem_pkg::mem_funct3_t'(funct3))
            rv32i_mem_pkg::mem_byte,
            rv32i_mem_pkg::mem_byte_unsigned: begin
                lane_mask = 4'b0001 << offset;
            end
            rv32i_mem_pkg::mem_half,
            rv32i_mem_pkg::mem_half_unsigned: begin
                lane_mask = 4'b0011 << offset;
            end
            default: begin
                lane_mask = 4'b1111;
            end
        endcase
    end

    // ========================================================================
    // Data memory port
    // ========================================================================
    always_comb begin
        dmem_addr  = {mem_alu_out[`XLEN-1:2], 2'b00};
        dmem_rmask = (mem_valid && is_load) ? lane_mask : 4'b0000;
        dmem_wmask = (mem_valid && is_store) ? lane_mask : 4'b0000;

        // Move store data up to its byte lane
        dmem_wdata = mem_rs2_v << {offset, 3'b000};
    end

    // ========================================================================
    // Access checks
    // ========================================================================
    always_comb begin
        assert final ($isunknown(mem_valid)
                      || !(mem_valid && (is_load || is_store) && funct3[1:0] == 2'b01)
                      || !mem_alu_out[0])
            else $error("mem_stage: misaligned halfword access at %h", mem_alu_out);

        assert final ($isunknown(mem_valid)
                      || !(mem_valid && (is_load || is_store) && funct3[1:0] == 2'b10)
                      || (mem_alu_out[1:0] == 2'b00))
            else $error("mem_stage: misaligned word access at %h", mem_alu_out);
    end

endmodule

// ==== src/data_memory.sv ====
`timescale 1ns/1ps

`include "rv32i_mem_consts.svh"

module data_memory (
    input  logic              clk,
    input  logic [`XLEN-1:0]  dmem_addr,
    input  logic [3:0]        dmem_rmask,
    input  logic [3:0]        dmem_wmask,
    input  logic [`XLEN-1:0]  dmem_wdata,
    output logic [`XLEN-1:0]  dmem_rdata
);

    logic [`XLEN-1:0]           mem [`DMEM_WORDS];
    logic [`DMEM_INDEX_BITS-1:0] index;

    assign index = dmem_addr[`DMEM_INDEX_BITS+1:2];

    // ========================================================================
    // Byte writes
    // ========================================================================
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_wmask[b]) begin
                mem[index][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    // Registered read held while no read is requested
    always_ff @(posedge clk) begin
        if (|dmem_rmask) begin
            dmem_rdata <= mem[index];
        end
    end

    // ========================================================================
    // Address range check
    // ========================================================================
    addr_in_range: assert property (
        @(posedge clk)
        ((|dmem_rmask) || (|dmem_wmask))
            |-> (dmem_addr[`XLEN-1:`DMEM_INDEX_BITS+2] == '0)
    ) else $error("data_memory: address %h beyond array", dmem_addr);

endmodule

// ==== src/wb_stage.sv ====
`timescale 1ns/1ps

`include "rv32i_mem_consts.svh"

module wb_stage (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      mem_valid,
    input  rv32i_mem_pkg::rv32_inst_t mem_inst,
    input  logic [`XLEN-1:0]          mem_pc,
    input  logic [`XLEN-1:0]          mem_alu_out,
    input  logic [`XLEN-1:0]          dmem_rdata,

    output logic                      wb_valid,
    output logic [`XLEN-1:0]          wb_pc,
    output logic                      rd_we,
    output logic [4:0]                rd_addr,
    output logic [`XLEN-1:0]          rd_wdata
);

    rv32i_mem_pkg::rv32_inst_t wb_inst;
    logic [`XLEN-1:0]          wb_alu_out;
    logic [1:0]                offset;
    logic                      is_load;
    logic                      writes_rd;
    logic [7:0]                load_byte;
    logic [15:0]               load_half;
    logic [`XLEN-1:0]          load_data;

    // ========================================================================
    // MEM/WB register
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_inst    <= mem_inst;
        wb_pc      <= mem_pc;
        wb_alu_out <= mem_alu_out;
    end

    // ========================================================================
    // Load extraction
    // ========================================================================
    always_comb begin
        offset    = wb_alu_out[1:0];
        load_byte = dmem_rdata[{offset, 3'b000} +: 8];
        load_half = dmem_rdata[{offset[1], 4'b0000} +: 16];

        case (rv32i_mem_pkg::mem_funct3_t'(wb_inst.i.funct3))
            rv32i_mem_pkg::mem_byte:          load_data = {{24{load_byte[7]}}, load_byte};
            rv32i_mem_pkg::mem_byte_unsigned: load_data = {24'h000000, load_byte};
            rv32i_mem_pkg::mem_half:          load_data = {{16{load_half[15]}}, load_half};
            rv32i_mem_pkg::mem_half_unsigned: load_data = {16'h0000, load_half};
            default:                          load_data = dmem_rdata;
        endcase
    end

    // ========================================================================
    // Register file write port
    // ========================================================================
    always_comb begin
        is_load = (wb_inst.i.opcode == rv32i_mem_pkg::opc_load);

        case (wb_inst.i.opcode)
            rv32i_mem_pkg::opc_load,
            rv32i_mem_pkg::opc_op_imm,
            rv32i_mem_pkg::opc_op,
            rv32i_mem_pkg::opc_lui,
            rv32i_mem_pkg::opc_auipc: writes_rd = 1'b1;
            default:                  writes_rd = 1'b0;
        endcase

        rd_addr  = wb_inst.i.rd;
        rd_we    = wb_valid && writes_rd && (wb_inst.i.rd != 5'd0);
        rd_wdata = is_load ? load_data : wb_alu_out;
    end

endmodule

// ==== src/mem_backend_top.sv ====
`timescale 1ns/1ps

`include "rv32i_mem_consts.svh"

module mem_backend_top (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      in_valid,
    input  rv32i_mem_pkg::rv32_inst_t in_inst,
    input  logic [`XLEN-1:0]          in_pc,
    input  logic [`XLEN-1:0]          in_alu_out,
    input  logic [`XLEN-1:0]          in_rs2_v,

    output logic                      wb_valid,
    output logic [`XLEN-1:0]          wb_pc,
    output logic                      rd_we,
    output logic [4:0]                rd_addr,
    output logic [`XLEN-1:0]          rd_wdata,

    // Observation copies of the memory port
    output logic [`XLEN-1:0]          dmem_addr,
    output logic [3:0]                dmem_rmask,
    output logic [3:0]                dmem_wmask
);

    logic                      mem_valid;
    rv32i_mem_pkg::rv32_inst_t mem_inst;
    logic [`XLEN-1:0]          mem_pc;
    logic [`XLEN-1:0]          mem_alu_out;
    logic [`XLEN-1:0]          mem_rs2_v;
    logic [`XLEN-1:0]          dmem_wdata;
    logic [`XLEN-1:0]          dmem_rdata;

    // ========================================================================
    // Pipeline blocks
    // ========================================================================
    ex_mem_reg ex_mem_reg_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_pc       (in_pc),
        .in_alu_out  (in_alu_out),
        .in_rs2_v    (in_rs2_v),
        .mem_valid   (mem_valid),
        .mem_inst    (mem_inst),
        .mem_pc      (mem_pc),
        .mem_alu_out (mem_alu_out),
        .mem_rs2_v   (mem_rs2_v)
    );

    mem_stage mem_stage_inst (
        .mem_valid   (mem_valid),
        .mem_inst    (mem_inst),
        .mem_alu_out (mem_alu_out),
        .mem_rs2_v   (mem_rs2_v),
        .dmem_addr   (dmem_addr),
        .dmem_rmask  (dmem_rmask),
        .dmem_wmask  (dmem_wmask),
        .dmem_wdata  (dmem_wdata)
    );

    data_memory data_memory_inst (
        .clk        (clk),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    wb_stage wb_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .mem_valid   (mem_valid),
        .mem_inst    (mem_inst),
        .mem_pc      (mem_pc),
        .mem_alu_out (mem_alu_out),
        .dmem_rdata  (dmem_rdata),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata)
    );

endmodule

// ==== verification/mem_backend_tb.sv ====
`timescale 1ns/1ps

`include "rv32i_mem_consts.svh"

module mem_backend_tb;

    localparam int reset_cycles = 8;
    localparam int random_count = 200;
    // Memory fill, directed tests, random mix with bubbles and drain
    localparam int planned_slots = `DMEM_WORDS + 80 + 2 * random_count + 3;
    localparam int limit_cycles  = planned_slots + reset_cycles + 100;

    localparam logic [6:0] alu_codes [4] = '{rv32i_mem_pkg::opc_op_imm,
        rv32i_mem_pkg::opc_op, rv32i_mem_pkg::opc_lui, rv32i_mem_pkg::opc_auipc};
    localparam logic [2:0] load_codes [5] = '{rv32i_mem_pkg::mem_byte,
        rv32i_mem_pkg::mem_half, rv32i_mem_pkg::mem_word,
        rv32i_mem_pkg::mem_byte_unsigned, rv32i_mem_pkg::mem_half_unsigned};
    localparam logic [2:0] store_codes [3] = '{rv32i_mem_pkg::mem_byte,
        rv32i_mem_pkg::mem_half, rv32i_mem_pkg::mem_word};

    typedef struct packed {
        logic             valid;
        logic             we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] wdata;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] addr;
        logic [3:0]       rmask;
        logic [3:0]       wmask;
    } expect_t;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    rv32i_mem_pkg::rv32_inst_t in_inst;
    logic [`XLEN-1:0]          in_pc;
    logic [`XLEN-1:0]          in_alu_out;
    logic [`XLEN-1:0]          in_rs2_v;
    logic                      wb_valid;
    logic [`XLEN-1:0]          wb_pc;
    logic                      rd_we;
    logic [4:0]                rd_addr;
    logic [`XLEN-1:0]          rd_wdata;
    logic [`XLEN-1:0]          dmem_addr;
    logic [3:0]                dmem_rmask;
    logic [3:0]                dmem_wmask;

    logic [7:0]       mem_model [4*`DMEM_WORDS];
    expect_t          expected_q [$];
    logic [`XLEN-1:0] pc_next;
    integer           seed;
    logic             failed;

    mem_backend_top mem_backend_top_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_pc      (in_pc),
        .in_alu_out (in_alu_out),
        .in_rs2_v   (in_rs2_v),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .rd_we      (rd_we),
        .rd_addr    (rd_addr),
        .rd_wdata   (rd_wdata),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic fail_run(input string msg);
        failed = 1'b1;
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Bits 11:7 are rd for loads and ALU ops but imm_lo for stores
    function automatic rv32i_mem_pkg::rv32_inst_t make_inst(input logic [6:0] opcode,
                                                           input logic [4:0] rd,
                                                           input logic [2:0] funct3);
        rv32i_mem_pkg::rv32_inst_t inst;
        inst          = '0;
        inst.i.opcode = opcode;
        inst.i.rd     = rd;
        inst.i.funct3 = funct3;
        inst.i.rs1    = 5'd3;
        return inst;
    endfunction

    function automatic int access_size(input logic [2:0] funct3);
        case (funct3)
            rv32i_mem_pkg::mem_byte, rv32i_mem_pkg::mem_byte_unsigned: return 1;
            rv32i_mem_pkg::mem_half, rv32i_mem_pkg::mem_half_unsigned: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [31:0] fill_word(input logic [9:0] a);
        return {~a[9:2], a[9:2] ^ 8'h96, a[9:2] + 8'h31, a[9:2] ^ {a[3:2], a[9:4]}};
    endfunction

    task automatic send_slot(input logic valid, input rv32i_mem_pkg::rv32_inst_t inst,
                             input logic [`XLEN-1:0] alu_out, input logic [`XLEN-1:0] rs2_v,
                             input expect_t e);
        @(posedge clk);
        #2;
        in_valid   = valid;
        in_inst    = inst;
        in_pc      = pc_next;
        in_alu_out = alu_out;
        in_rs2_v   = rs2_v;
        e.pc       = pc_next;
        pc_next    = pc_next + 4;
        expected_q.push_back(e);
    endtask

    task automatic bubble();
        expect_t e;
        e = '0;
        send_slot(1'b0, rv32i_mem_pkg::rv32_inst_t'($random(seed)), $random(seed),
                  $random(seed), e);
    endtask

    task automatic alu_op(input logic [6:0] opcode, input logic [4:0] rd,
                          input logic [`XLEN-1:0] value);
        expect_t e;
        e       = '0;
        e.valid = 1'b1;
        e.we    = (rd != 5'd0);
        e.rd    = rd;
        e.wdata = value;
        send_slot(1'b1, make_inst(opcode, rd, 3'b000), value, $random(seed), e);
    endtask

    task automatic mem_access(input logic is_store, input logic [2:0] funct3,
                              input logic [4:0] rd, input logic [`XLEN-1:0] raw_addr,
                              input logic [`XLEN-1:0] data);
        expect_t          e;
        int               size;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] value;
        logic [3:0]       lanes;
        size    = access_size(funct3);
        addr    = raw_addr & (4 * `DMEM_WORDS - size);
        value   = '0;
        lanes   = '0;
        e       = '0;
        e.valid = 1'b1;
        e.addr  = {addr[`XLEN-1:2], 2'b00};
        for (int k = 0; k < size; k++) begin
            lanes[addr[1:0] + k] = 1'b1;
            if (is_store) begin
                mem_model[addr + k] = data[8*k +: 8];
            end else begin
                value[8*k +: 8] = mem_model[addr + k];
            end
        end
        if (is_store) begin
            e.wmask = lanes;
            send_slot(1'b1, make_inst(rv32i_mem_pkg::opc_store, 5'h15, funct3), addr, data, e);
        end else begin
            case (funct3)
                rv32i_mem_pkg::mem_byte: value = {{24{value[7]}}, value[7:0]};
                rv32i_mem_pkg::mem_half: value = {{16{value[15]}}, value[15:0]};
                default: value = value;
            endcase
            e.rmask = lanes;
            e.we    = (rd != 5'd0);
            e.rd    = rd;
            e.wdata = value;
            send_slot(1'b1, make_inst(rv32i_mem_pkg::opc_load, rd, funct3), addr, data, e);
        end
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    reset_quiet: assert property (
        @(posedge clk) reset |=> (!wb_valid && !rd_we && dmem_rmask == 4'h0 && dmem_wmask == 4'h0)
    ) else fail_run("Write-back or memory port active while reset is held");

    we_needs_valid: assert property (
        @(posedge clk) disable iff (reset) rd_we |-> wb_valid
    ) else fail_run("rd_we went high without wb_valid");

    // Memory port shows the slot issued one cycle ago and write-back the one before
    always @(negedge clk) begin : check_outputs
        int      n;
        expect_t pe;
        expect_t we;
        n = expected_q.size();
        if (n >= 2) begin
            pe = expected_q[n-2];
            check_value("dmem_rmask", pe.rmask, dmem_rmask);
            check_value("dmem_wmask", pe.wmask, dmem_wmask);
            if (pe.rmask != 4'h0 || pe.wmask != 4'h0) begin
                check_value("dmem_addr", pe.addr, dmem_addr);
            end
        end
        if (n == 3) begin
            we = expected_q.pop_front();
            check_value("wb_valid", we.valid, wb_valid);
            check_value("rd_we", we.we, rd_we);
            if (we.valid) begin
                check_value("wb_pc", we.pc, wb_pc);
            end
            if (we.we) begin
                check_value("rd_addr", we.rd, rd_addr);
                check_value("rd_wdata", we.wdata, rd_wdata);
            end
        end
    end

    initial begin : watchdog
        #(limit_cycles * 20);
        fail_run("Timeout: the run did not finish within the expected time");
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin : stimulus
        int               kind;
        logic [`XLEN-1:0] base;
        logic [4:0]       rd;
        seed       = 32'h5ae8;
        failed     = 1'b0;
        pc_next    = 32'h0000_1000;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_inst    = '0;
        in_pc      = '0;
        in_alu_out = '0;
        in_rs2_v   = '0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (4) bubble();
        for (int k = 0; k < 4; k++) begin
            alu_op(alu_codes[k], 5'(1 + {$random(seed)} % 31), $random(seed));
            alu_op(alu_codes[k], 5'd0, $random(seed));
        end

        // Fill so every later load reads known data
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            mem_access(1'b1, rv32i_mem_pkg::mem_word, 5'd0, w * 4, fill_word(10'(w * 4)));
        end

        for (int k = 0; k < 4; k++) begin
            base = ({$random(seed)} % `DMEM_WORDS) * 4;
            mem_access(1'b1, rv32i_mem_pkg::mem_word, 5'd0, base, $random(seed));
            mem_access(1'b0, rv32i_mem_pkg::mem_word, 5'(5 + k), base, 32'h0);
        end

        base = ({$random(seed)} % `DMEM_WORDS) * 4;
        for (int off = 0; off < 4; off++) begin
            mem_access(1'b1, rv32i_mem_pkg::mem_byte, 5'd0, base + off, $random(seed));
            mem_access(1'b0, rv32i_mem_pkg::mem_word, 5'd9, base, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            mem_access(1'b1, rv32i_mem_pkg::mem_half, 5'd0, base + off, $random(seed));
            mem_access(1'b0, rv32i_mem_pkg::mem_word, 5'd10, base, 32'h0);
        end

        // Lanes with top bits all set and then all clear
        for (int p = 0; p < 2; p++) begin
            base = ({$random(seed)} % `DMEM_WORDS) * 4;
            mem_access(1'b1, rv32i_mem_pkg::mem_word, 5'd0, base,
                       (p == 0) ? 32'h8fc3_a5f0 : 32'h7e3c_5a0f);
            for (int off = 0; off < 4; off++) begin
                mem_access(1'b0, rv32i_mem_pkg::mem_byte, 5'd11, base + off, 32'h0);
                mem_access(1'b0, rv32i_mem_pkg::mem_byte_unsigned, 5'd12, base + off, 32'h0);
                if (off % 2 == 0) begin
                    mem_access(1'b0, rv32i_mem_pkg::mem_half, 5'd13, base + off, 32'h0);
                    mem_access(1'b0, rv32i_mem_pkg::mem_half_unsigned, 5'd14, base + off, 0);
                end
            end
        end

        for (int i = 0; i < random_count; i++) begin
            if (({$random(seed)} % 8) == 0) begin
                bubble();
            end
            kind = {$random(seed)} % 3;
            base = {$random(seed)} % (4 * `DMEM_WORDS);
            rd   = 5'({$random(seed)} % 32);
            case (kind)
                0: mem_access(1'b0, load_codes[{$random(seed)} % 5], rd, base, $random(seed));
                1: mem_access(1'b1, store_codes[{$random(seed)} % 3], rd, base, $random(seed));
                default: alu_op(alu_codes[{$random(seed)} % 4], rd, $random(seed));
            endcase
        end

        repeat (3) bubble();
        @(posedge clk);
        if (!failed) begin
            $display("** PASS **");
            $finish;
        end else begin
            fail_run("A check failed during the run");
        end
    end

endmodule

// ==== rv32i_mem_backend.f ====
+incdir+src
src/rv32i_mem_pkg.sv
src/ex_mem_reg.sv
src/mem_stage.sv
src/data_memory.sv
src/wb_stage.sv
src/mem_backend_top.sv
verification/mem_backend_tb.sv
